/* all.f */
+incdir+logic
+incdir+tests
logic/heapPkg.sv
logic/accessCheck.sv
logic/arrayAllocator.sv
logic/sizeTable.sv
logic/elementStore.sv
logic/heapMemory.sv
tests/heapMemoryTb.sv

/* logic/accessCheck.sv */
// Command checker
// Validates each command against allocation state and size, registers the error

`timescale 1ns/1ns

`include "heap_config.svh"

module accessCheck (
  input  logic                        clock,
  input  logic                        reset,
  input  heapPkg::heapRequest_t       request,
  input  logic                        allocated,           // Flag of requested array
  input  logic [`HEAP_ADDRESS_BITS:0] highWater,           // Arrays ever handed out
  input  logic                        noHandle,            // Pool exhausted
  input  heapPkg::size_t              curSize,             // Size of requested array
  output logic                        commit,              // Command may change state
  output heapPkg::heapError_t         error
);
  import heapPkg::*;

  logic       isIdle;
  logic       needsIndex;                                  // Index must be inside size
  heapError_t checkError;

  assign isIdle     = (request.action == actIdle);
  assign needsIndex = request.action inside {actRead, actAdd, actAddAfter, actSub,
                                             actSubAfter, actOr, actXor, actAnd};

  // Checks in priority order
  always_comb begin
    checkError = errNone;
    if (request.action == actAlloc) begin
      if (noHandle) checkError = errOutOfMemory;
    end else if (!isIdle) begin
      if ({1'b0, request.arrayId} >= highWater) begin
        checkError = errNotAllocated;                      // Never handed out
      end else if (!allocated) begin
        checkError = errFreed;
      end else if (needsIndex && (size_t'(request.index) >= curSize)) begin
        checkError = errOutOfBounds;
      end else if ((request.action == actPush) && (curSize == size_t'(`HEAP_LENGTH))) begin
        checkError = errFull;
      end else if ((request.action == actPop) && (curSize == '0)) begin
        checkError = errEmpty;
      end
    end
  end

  assign commit = !isIdle && (checkError == errNone);

  always_ff @(posedge clock) begin
    if (reset) begin
      error <= errNone;
    end else if (!isIdle) begin
      error <= checkError;                                 // Idle keeps last error
    end
  end

endmodule

/* logic/arrayAllocator.sv */
// Array allocator
// High-water count, allocation flags and a LIFO of freed arrays

`timescale 1ns/1ns

`include "heap_config.svh"

module arrayAllocator (
  input  logic                        clock,
  input  logic                        reset,
  input  heapPkg::heapRequest_t       request,
  input  logic                        commit,              // Apply this command
  output logic                        allocated,           // Flag of requested array
  output logic [`HEAP_ADDRESS_BITS:0] highWater,           // Arrays ever handed out
  output heapPkg::arrayId_t           allocHandle,         // Handle alloc would get
  output logic                        noHandle             // Nothing left to give
);
  import heapPkg::*;

  logic [`HEAP_ARRAYS-1:0]     allocFlags;                 // One bit per array
  arrayId_t                    freeStack [`HEAP_ARRAYS];   // Freed arrays, LIFO
  logic [`HEAP_ADDRESS_BITS:0] stackTop;                   // Entries on the stack
  logic                        stackEmpty;
  logic                        doAlloc;
  logic                        doFree;

  // ------------------------------------------------------------
  // Handle choice
  // ------------------------------------------------------------
  assign stackEmpty = (stackTop == '0);
  assign doAlloc    = commit && (request.action == actAlloc);
  assign doFree     = commit && (request.action == actFree);

  always_comb begin
    if (!stackEmpty) begin
      allocHandle = freeStack[stackTop[`HEAP_ADDRESS_BITS-1:0] - 1'b1];  // Reuse newest free
    end else begin
      allocHandle = highWater[`HEAP_ADDRESS_BITS-1:0];    // Fresh array
    end
  end

  // Every array handed out and none returned
  assign noHandle  = stackEmpty && (highWater == (`HEAP_ADDRESS_BITS+1)'(`HEAP_ARRAYS));
  assign allocated = allocFlags[request.arrayId];

  // ------------------------------------------------------------
  // Control state
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocFlags <= '0;                                    // Nothing allocated
      stackTop   <= '0;                                    // Stack empty
      highWater  <= '0;
    end else if (doAlloc) begin
      allocFlags[allocHandle] <= 1'b1;
      if (!stackEmpty) begin
        stackTop <= stackTop - 1'b1;                       // Pop the freed array
      end else begin
        highWater <= highWater + 1'b1;                     // Advance into new space
      end
    end else if (doFree) begin
      allocFlags[request.arrayId] <= 1'b0;
      stackTop                    <= stackTop + 1'b1;
    end
  end

  // Stack contents, only meaningful below stackTop
  always_ff @(posedge clock) begin
    if (doFree) begin
      freeStack[stackTop[`HEAP_ADDRESS_BITS-1:0]] <= request.arrayId;
    end
  end

endmodule

/* logic/elementStore.sv */
// Element storage
// Holds the array elements, applies the element operations and registers the result word

`timescale 1ns/1ns

`include "heap_config.svh"

module elementStore (
  input  logic                  clock,
  input  logic                  reset,
  input  heapPkg::heapRequest_t request,
  input  logic                  commit,                    // Apply this command
  input  heapPkg::arrayId_t     allocHandle,               // Handle an alloc returns
  input  heapPkg::size_t        curSize,                   // Size of requested array
  output heapPkg::heapWord_u    word                       // Registered result word
);
  import heapPkg::*;

  data_t     store [`HEAP_ARRAYS][`HEAP_LENGTH];           // All elements, fixed slots
  index_t    slot;                                         // Element addressed
  data_t     stored;                                       // Its current value
  data_t     newValue;                                     // Value written back
  logic      writesElement;
  logic      returnsWord;                                  // Command yields a result
  heapWord_u nextWord;

  // ------------------------------------------------------------
  // Slot selection
  // ------------------------------------------------------------
  always_comb begin
    case (request.action)
      actPush: slot = index_t'(curSize);                   // One past the last
      actPop:  slot = index_t'(curSize - size_t'(1));      // The last element
      default: slot = request.index;
    endcase
  end

  assign stored = store[request.arrayId][slot];

  // ------------------------------------------------------------
  // Element operations
  // ------------------------------------------------------------
  always_comb begin
    case (request.action)
      actAdd, actAddAfter: newValue = stored + request.data;   // Wraps at data width
      actSub, actSubAfter: newValue = stored - request.data;
      actOr:               newValue = stored | request.data;
      actXor:              newValue = stored ^ request.data;
      actAnd:              newValue = stored & request.data;
      default:             newValue = request.data;        // Write and push
    endcase
  end

  assign writesElement = request.action inside {actWrite, actPush, actAdd, actAddAfter,
                                                actSub, actSubAfter, actOr, actXor, actAnd};

  // ------------------------------------------------------------
  // Result word
  // ------------------------------------------------------------
  always_comb begin
    nextWord    = '0;
    returnsWord = 1'b1;
    case (request.action)
      actWrite: begin
        nextWord.element = request.data;                   // Echo written data
      end
      actRead, actPop, actAddAfter, actSubAfter: begin
        nextWord.element = stored;                         // Value before the op
      end
      actAdd, actSub, actOr, actXor, actAnd: begin
        nextWord.element = newValue;
      end
      actSize: begin
        nextWord.handle.arrayId = request.arrayId;
        nextWord.handle.size    = curSize;
      end
      actAlloc: begin
        nextWord.handle.arrayId = allocHandle;             // New array starts empty
        nextWord.handle.size    = '0;
      end
      default: begin
        returnsWord = 1'b0;                                // Push and free keep word
      end
    endcase
  end

  // Storage write back
  always_ff @(posedge clock) begin
    if (commit && writesElement) begin
      store[request.arrayId][slot] <= newValue;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      word <= '0;
    end else if (commit && returnsWord) begin
      word <= nextWord;
    end
  end

endmodule

/* logic/heapMemory.sv */
// Heap memory top level
// Fixed pool of small arrays, one command per clock, one cycle latency

`timescale 1ns/1ns

`include "heap_config.svh"

module heapMemory (
  input  logic                   clock,
  input  logic                   reset,
  input  heapPkg::heapRequest_t  request,                  // Command sampled every edge
  output heapPkg::heapResponse_t response                  // Result of the last command
);
  import heapPkg::*;

  logic                      commit;                       // Command passed all checks
  logic                      allocated;                    // Flag of requested array
  logic                      noHandle;                     // Pool exhausted
  logic [`HEAP_ADDRESS_BITS:0] highWater;                  // Arrays ever handed out
  arrayId_t                  allocHandle;                  // Next handle for alloc
  size_t                     curSize;                      // Size of requested array
  heapWord_u                 word;
  heapError_t                error;

  accessCheck accessCheck_i (
    .clock    (clock),
    .reset    (reset),
    .request  (request),
    .allocated(allocated),
    .highWater(highWater),
    .noHandle (noHandle),
    .curSize  (curSize),
    .commit   (commit),
    .error    (error)
  );

  arrayAllocator arrayAllocator_i (
    .clock      (clock),
    .reset      (reset),
    .request    (request),
    .commit     (commit),
    .allocated  (allocated),
    .highWater  (highWater),
    .allocHandle(allocHandle),
    .noHandle   (noHandle)
  );

  sizeTable sizeTable_i (
    .clock      (clock),
    .reset      (reset),
    .request    (request),
    .commit     (commit),
    .allocHandle(allocHandle),
    .curSize    (curSize)
  );

  elementStore elementStore_i (
    .clock      (clock),
    .reset      (reset),
    .request    (request),
    .commit     (commit),
    .allocHandle(allocHandle),
    .curSize    (curSize),
    .word       (word)
  );

  assign response = '{word: word, error: error};           // Pack outgoing response

endmodule

/* logic/heapPkg.sv */
// Heap memory types
// Command and error encodings, request and response words, result word views

`include "heap_config.svh"

package heapPkg;

  // ------------------------------------------------------------
  // Encodings
  // ------------------------------------------------------------
  typedef enum logic [4:0] {
    actIdle,                                                // No command this cycle
    actWrite,                                               // Store an element
    actRead,                                                // Fetch an element
    actSize,                                                // Query array size
    actPush,                                                // Append at the end
    actPop,                                                 // Remove from the end
    actAlloc,                                               // Get a fresh array
    actFree,                                                // Return an array
    actAdd,                                                 // Add, new value out
    actAddAfter,                                            // Add, old value out
    actSub,                                                 // Subtract, new value out
    actSubAfter,                                            // Subtract, old value out
    actOr,
    actXor,
    actAnd
  } heapAction_t;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                        // Above high-water count
    errFreed,                                               // Array was freed
    errOutOfBounds,                                         // Index at or past size
    errFull,                                                // Push onto full array
    errEmpty,                                               // Pop from empty array
    errOutOfMemory                                          // No handle left
  } heapError_t;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayId_t;
  typedef logic [`HEAP_INDEX_BITS-1:0]   index_t;
  typedef logic [`HEAP_INDEX_BITS:0]     size_t;           // One extra bit for full
  typedef logic [`HEAP_DATA_BITS-1:0]    data_t;

  // ------------------------------------------------------------
  // Bundles
  // ------------------------------------------------------------
  typedef struct packed {
    heapAction_t action;
    arrayId_t    arrayId;
    index_t      index;
    data_t       data;
  } heapRequest_t;

  typedef struct packed {
    logic [`HEAP_DATA_BITS-`HEAP_ADDRESS_BITS-`HEAP_INDEX_BITS-2:0] pad;  // Always zero
    arrayId_t arrayId;
    size_t    size;
  } heapHandle_t;

  // Result word read either as element data or as handle plus size
  typedef union packed {
    data_t       element;
    heapHandle_t handle;
  } heapWord_u;

  typedef struct packed {
    heapWord_u  word;
    heapError_t error;
  } heapResponse_t;

endpackage

/* logic/heap_config.svh */
// Heap memory configuration
// Widths of the array number, element index and element data, plus derived sizes

`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// ------------------------------------------------------------
// Base widths
// ------------------------------------------------------------
`define HEAP_ADDRESS_BITS 2                                 // Bits in an array number
`define HEAP_INDEX_BITS   2                                 // Bits in an element index
`define HEAP_DATA_BITS    12                                // Bits in one element

// ------------------------------------------------------------
// Derived sizes
// ------------------------------------------------------------
`define HEAP_ARRAYS (1 << `HEAP_ADDRESS_BITS)               // Number of arrays
`define HEAP_LENGTH (1 << `HEAP_INDEX_BITS)                 // Max elements per array

`endif

/* logic/sizeTable.sv */
// Array size table
// Current element count of every array, updated by committed commands

`timescale 1ns/1ns

`include "heap_config.svh"

module sizeTable (
  input  logic                  clock,
  input  logic                  reset,
  input  heapPkg::heapRequest_t request,
  input  logic                  commit,                    // Apply this command
  input  heapPkg::arrayId_t     allocHandle,               // Array an alloc takes
  output heapPkg::size_t        curSize                    // Size of requested array
);
  import heapPkg::*;

  size_t sizes [`HEAP_ARRAYS];                             // One count per array
  size_t writeEnd;                                         // Size implied by a write

  assign curSize  = sizes[request.arrayId];
  assign writeEnd = size_t'(request.index) + size_t'(1);

  // ------------------------------------------------------------
  // Size rules
  // ------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else if (commit) begin
      case (request.action)
        actAlloc: begin
          sizes[allocHandle] <= '0;                        // Fresh array is empty
        end
        actWrite: begin
          if (writeEnd > curSize) begin
            sizes[request.arrayId] <= writeEnd;            // Grow past written slot
          end
        end
        actPush: begin
          sizes[request.arrayId] <= curSize + 1'b1;
        end
        actPop: begin
          sizes[request.arrayId] <= curSize - 1'b1;
        end
        default: begin
          // Other commands leave sizes alone
        end
      endcase
    end
  end

endmodule

/* tests/heapModel.svh */
// Heap memory reference model
// Tracks flags, sizes, elements and the free stack, predicts each response

`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

// ------------------------------------------------------------
// Model state
// ------------------------------------------------------------
logic          modelAllocated [`HEAP_ARRAYS];              // Allocation flags
int            modelSize      [`HEAP_ARRAYS];              // Element counts
data_t         modelElements  [`HEAP_ARRAYS][`HEAP_LENGTH];  // Kept across reset
arrayId_t      modelFree      [$];                         // Freed arrays, newest at back
int            modelHighWater;                             // Arrays ever handed out
heapResponse_t modelResponse;                              // Last predicted response

// Handle view of the result word, returned as plain data
function automatic data_t handleWord(input int id, input int size);
  heapWord_u packedWord;
  packedWord                = '0;
  packedWord.handle.arrayId = arrayId_t'(id);
  packedWord.handle.size    = size_t'(size);
  return packedWord.element;
endfunction

function automatic void modelReset();
  for (int i = 0; i < `HEAP_ARRAYS; i++) begin
    modelAllocated[i] = 1'b0;
    modelSize[i]      = 0;
  end
  modelFree.delete();
  modelHighWater = 0;
  modelResponse  = '0;                                     // Word 0, no error
endfunction

// Applies one command to the model and returns the response it should produce
function automatic heapResponse_t heapExpect(input heapRequest_t req);
  heapError_t code;
  data_t      old;
  data_t      result;
  int         id;
  int         index;
  int         handle;
  code  = errNone;
  id    = int'(req.arrayId);
  index = int'(req.index);
  if (req.action == actIdle) begin
    return modelResponse;                                  // Nothing changes
  end
  if (req.action == actAlloc) begin
    if (modelFree.size() == 0 && modelHighWater == `HEAP_ARRAYS) code = errOutOfMemory;
  end else if (id >= modelHighWater) begin
    code = errNotAllocated;
  end else if (!modelAllocated[id]) begin
    code = errFreed;
  end else if (req.action inside {actRead, actAdd, actAddAfter, actSub, actSubAfter,
                                  actOr, actXor, actAnd} && index >= modelSize[id]) begin
    code = errOutOfBounds;
  end else if (req.action == actPush && modelSize[id] == `HEAP_LENGTH) begin
    code = errFull;
  end else if (req.action == actPop && modelSize[id] == 0) begin
    code = errEmpty;
  end
  modelResponse.error = code;
  if (code != errNone) begin
    return modelResponse;                                  // Rejected, word kept
  end
  old = modelElements[id][index];
  case (req.action)
    actWrite: begin
      modelElements[id][index] = req.data;
      if (index + 1 > modelSize[id]) modelSize[id] = index + 1;  // Grow to cover slot
      modelResponse.word.element = req.data;
    end
    actRead: modelResponse.word.element = old;
    actSize: modelResponse.word.element = handleWord(id, modelSize[id]);
    actPush: begin
      modelElements[id][modelSize[id]] = req.data;         // Append, word kept
      modelSize[id]++;
    end
    actPop: begin
      modelSize[id]--;
      modelResponse.word.element = modelElements[id][modelSize[id]];
    end
    actAlloc: begin
      if (modelFree.size() > 0) begin
        handle = int'(modelFree.pop_back());               // Newest freed first
      end else begin
        handle = modelHighWater;
        modelHighWater++;
      end
      modelAllocated[handle]     = 1'b1;
      modelSize[handle]          = 0;
      modelResponse.word.element = handleWord(handle, 0);
    end
    actFree: begin
      modelAllocated[id] = 1'b0;
      modelFree.push_back(req.arrayId);
    end
    default: begin
      case (req.action)
        actAdd, actAddAfter: result = old + req.data;      // Truncates to data width
        actSub, actSubAfter: result = old - req.data;
        actOr:               result = old | req.data;
        actXor:              result = old ^ req.data;
        default:             result = old & req.data;
      endcase
      modelElements[id][index]   = result;
      modelResponse.word.element = (req.action inside {actAddAfter, actSubAfter}) ? old : result;
    end
  endcase
  return modelResponse;
endfunction

`endif

/* tests/heapMemoryTb.sv */
// Heap memory testbench
// Directed and random commands checked against the reference model

`timescale 1ns/1ns

`include "heap_config.svh"

module heapMemoryTb;
  import heapPkg::*;

  `include "heapModel.svh"

  localparam int resetCycles  = 16;
  localparam int resetTimeout = 100;                       // Cycles allowed for reset
  localparam int randomCount  = 400;

  logic          clock;
  logic          reset;
  heapRequest_t  request;
  heapResponse_t response;
  heapResponse_t expected;                                 // Model prediction
  logic          expectValid = 1'b0;                       // Set after first edge
  int            errorCount  = 0;
  int            checkCount  = 0;

  heapMemory dut_i (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .response(response)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                             // 8 ns period
  end

  task automatic checkValue(input string name, input logic [31:0] want,
                            input logic [31:0] got);
    checkCount++;
    if (got !== want) begin
      errorCount++;
      $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, want, got);
    end
  endtask

  // ------------------------------------------------------------
  // Model and comparison
  // ------------------------------------------------------------
  always @(posedge clock) begin
    if (reset) begin
      modelReset();
      expected = modelResponse;
    end else begin
      expected = heapExpect(request);                      // Command the DUT samples now
    end
    expectValid = 1'b1;
  end

  always @(negedge clock) begin
    if (expectValid) begin
      checkValue("response.word", expected.word, response.word);
      checkValue("response.error", expected.error, response.error);
    end
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic sendCommand(input heapAction_t action, input int id, input int index,
                             input int data);
    @(posedge clock);
    request <= '{action: action, arrayId: arrayId_t'(id), index: index_t'(index),
                 data: data_t'(data)};
  endtask

  // Command then idle so the response is settled
  task automatic runCommand(input heapAction_t action, input int id, input int index,
                            input int data);
    sendCommand(action, id, index, data);
    sendCommand(actIdle, 0, 0, 0);
    @(negedge clock);
  endtask

  task automatic expectResult(input string what, input int word, input heapError_t code);
    checkValue({what, ": response.word"}, word, response.word);
    checkValue({what, ": response.error"}, code, response.error);
  endtask

  task automatic expectError(input string what, input heapError_t code);
    checkValue({what, ": response.error"}, code, response.error);
  endtask

  // ------------------------------------------------------------
  // Directed sequences
  // ------------------------------------------------------------
  task automatic runDirectedChecks();
    // Nothing handed out yet
    runCommand(actRead, 1, 0, 0);
    expectResult("read before alloc", 0, errNotAllocated);

    // Fill the pool and ask once more
    for (int h = 0; h < `HEAP_ARRAYS; h++) begin
      runCommand(actAlloc, 0, 0, 0);
      expectResult("alloc", handleWord(h, 0), errNone);
    end
    runCommand(actAlloc, 0, 0, 0);
    expectResult("alloc when exhausted", handleWord(3, 0), errOutOfMemory);

    // Push, read back, pop past empty, push past full
    runCommand(actPush, 0, 0, 1);
    expectError("push 1", errNone);
    runCommand(actPush, 0, 0, 2);
    runCommand(actRead, 0, 0, 0);
    expectResult("read 0", 1, errNone);
    runCommand(actRead, 0, 1, 0);
    expectResult("read 1", 2, errNone);
    runCommand(actPop, 0, 0, 0);
    expectResult("first pop", 2, errNone);
    runCommand(actPop, 0, 0, 0);
    expectResult("second pop", 1, errNone);
    runCommand(actPop, 0, 0, 0);
    expectResult("pop empty", 1, errEmpty);
    for (int k = 0; k < `HEAP_LENGTH; k++) begin
      runCommand(actPush, 0, 0, k + 10);
      expectError("fill push", errNone);
    end
    runCommand(actPush, 0, 0, 99);
    expectError("push full", errFull);

    // Write past the end grows the size
    runCommand(actWrite, 1, 2, 7);
    expectResult("write index 2", 7, errNone);
    runCommand(actSize, 1, 0, 0);
    expectResult("size after write", handleWord(1, 3), errNone);
    runCommand(actRead, 1, 3, 0);
    expectError("read past size", errOutOfBounds);

    // Free, stale access, double free, LIFO reuse
    runCommand(actFree, 2, 0, 0);
    expectError("free 2", errNone);
    runCommand(actRead, 2, 0, 0);
    expectError("read freed", errFreed);
    runCommand(actFree, 2, 0, 0);
    expectError("double free", errFreed);
    runCommand(actAlloc, 0, 0, 0);
    expectResult("realloc", handleWord(2, 0), errNone);
    runCommand(actFree, 1, 0, 0);
    runCommand(actFree, 3, 0, 0);
    runCommand(actAlloc, 0, 0, 0);
    expectResult("reuse newest", handleWord(3, 0), errNone);
    runCommand(actAlloc, 0, 0, 0);
    expectResult("reuse older", handleWord(1, 0), errNone);

    // Mid-run reset
    @(posedge clock);
    reset <= 1'b1;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    expectResult("after reset", 0, errNone);
    runCommand(actAlloc, 0, 0, 0);
    expectResult("first alloc after reset", handleWord(0, 0), errNone);
    runCommand(actRead, 2, 0, 0);
    expectError("above high water", errNotAllocated);
  endtask

  task automatic runRandomCommands();
    // Every slot written before random reads
    for (int a = 1; a < `HEAP_ARRAYS; a++) sendCommand(actAlloc, 0, 0, 0);
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      for (int k = 0; k < `HEAP_LENGTH; k++) sendCommand(actPush, a, 0, $urandom);
    end

    // Back-to-back random commands
    for (int n = 0; n < randomCount; n++) begin
      sendCommand(heapAction_t'($urandom_range(14, 1)), $urandom_range(3, 0),
                  $urandom_range(3, 0), $urandom);
    end
    runCommand(actIdle, 0, 0, 0);
    @(posedge clock);                                      // Last comparison done
  endtask

  initial begin : stimulus
    int waitCycles;
    reset   = 1'b1;
    request = '0;                                          // Idle
    void'($urandom(32'hcf5d_6ed8));
    repeat (resetCycles) @(posedge clock);
    reset <= 1'b0;
    waitCycles = 0;
    @(negedge clock);
    while (response !== '0 && waitCycles < resetTimeout) begin  // DUT in its reset state
      @(negedge clock);
      waitCycles++;
    end
    if (response !== '0) begin
      errorCount++;
      $display("DUT response did not reach its reset value within %0d cycles", resetTimeout);
    end else begin
      runDirectedChecks();
      runRandomCommands();
    end

    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
